/* filelist.f */
src/ps2_kbd_pkg.sv
src/ps2_line_filter.sv
src/ps2_frame_rx.sv
src/ps2_prefix_tracker.sv
src/scan_code_map.sv
src/key_event_merge.sv
src/ps2_kbd_top.sv
dv/ps2_kbd_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := ps2_kbd_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := *** PASSED ***

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* dv/ps2_kbd_tb.sv */
`timescale 1ns/1ps

module ps2_kbd_tb
    import ps2_kbd_pkg::*;
;

    // Frames sent by the stimulus, used to size the watchdog
    localparam int RAND_PRESSES   = 8;
    localparam int RAND_UNMAPPED  = 12;
    localparam int NUM_FRAMES     = 19 + 5 + 3 * RAND_PRESSES + 5 + RAND_UNMAPPED + 2 + 3;
    localparam int WATCHDOG_CLKS  = NUM_FRAMES * 1000 + 2 * FRAME_TIMEOUT + 2000;

    typedef struct packed {
        key_event_t ev;
        logic       held_valid;
        logic [4:0] held_code;
    } expect_t;

    logic       clk;
    logic       rstn;
    logic       ps2_clk;
    logic       ps2_data;
    key_event_t key;
    logic       key_valid;
    logic       frame_err;
    logic       held_valid;
    logic [4:0] held_code;

    expect_t    exp_q[$];
    expect_t    expd;
    logic [7:0] table_bytes[19] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36,
                                    8'h3D, 8'h3E, 8'h46, 8'h1C, 8'h32, 8'h21, 8'h23,
                                    8'h24, 8'h2B, 8'h5A, 8'h66, 8'h0D};
    integer     seed = 32'hc065f6f6;
    int         value_errors = 0;
    int         other_errors = 0;
    int         ferr_count = 0;

    // Keyboard side prefix and held key model
    logic       pend_brk = 1'b0;
    logic       pend_ext = 1'b0;
    logic       model_held_valid = 1'b0;
    logic [4:0] model_held_code = KEY_NONE;

    ps2_kbd_top u_dut (
        .clk        (clk),
        .rstn       (rstn),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .key        (key),
        .key_valid  (key_valid),
        .frame_err  (frame_err),
        .held_valid (held_valid),
        .held_code  (held_code)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ##############################
    // Reference model
    // ##############################

    function automatic logic [4:0] table_code(input logic [7:0] b);
        logic [4:0] c;
        c = KEY_NONE;
        foreach (table_bytes[k]) begin
            if (table_bytes[k] == b) c = 5'(k);
        end
        return c;
    endfunction

    function automatic expect_t ref_event(input logic [7:0] b, input logic brk,
                                          input logic ext, input logic hv,
                                          input logic [4:0] hc);
        expect_t r;
        r.ev.code     = table_code(b);
        r.ev.released = brk;
        r.ev.extended = ext;
        r.held_valid  = hv;
        r.held_code   = hc;
        if (!brk) begin
            r.held_valid = 1'b1;
            r.held_code  = r.ev.code;
        end else if (r.ev.code == hc) begin
            r.held_valid = 1'b0;
        end
        return r;
    endfunction

    // ##############################
    // Line model
    // ##############################

    task automatic wait_clks(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Sends the first nbits of a frame, optionally with bad parity or clock glitches
    task automatic send_frame(input logic [7:0] b, input bit bad_parity,
                              input bit glitch, input int nbits);
        logic [10:0] bits;
        int          n;
        bits = {1'b1, (~^b) ^ bad_parity, b, 1'b0};
        n = 0;
        repeat (nbits) begin
            ps2_data = bits[0];
            bits = bits >> 1;
            if (glitch && (n == 3 || n == 7)) begin
                // Short low pulse once the filtered clock has settled high
                wait_clks(20);
                ps2_clk = 1'b0;
                wait_clks(5);
                ps2_clk = 1'b1;
                wait_clks(20);
            end else begin
                wait_clks(20);
            end
            ps2_clk = 1'b0;
            wait_clks(40);
            ps2_clk = 1'b1;
            wait_clks(20);
            n++;
        end
        ps2_data = 1'b1;
        wait_clks(100);
    endtask

    task automatic send_byte(input logic [7:0] b);
        expect_t e;
        if (b == SC_EXTEND) begin
            pend_ext = 1'b1;
        end else if (b == SC_BREAK) begin
            pend_brk = 1'b1;
        end else begin
            e = ref_event(b, pend_brk, pend_ext, model_held_valid, model_held_code);
            exp_q.push_back(e);
            model_held_valid = e.held_valid;
            model_held_code  = e.held_code;
            pend_brk = 1'b0;
            pend_ext = 1'b0;
        end
        send_frame(b, 1'b0, 1'b0, 11);
    endtask

    // ##############################
    // Checking
    // ##############################

    always @(negedge clk) begin
        if (rstn && key_valid) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected key event with code %0d at %0t", key.code, $time);
                other_errors++;
            end else begin
                expd = exp_q.pop_front();
                if (key !== expd.ev) begin
                    $display("FAIL %0t: key code %0d rel %0b ext %0b, expected %0d %0b %0b",
                             $time, key.code, key.released, key.extended,
                             expd.ev.code, expd.ev.released, expd.ev.extended);
                    value_errors++;
                end
                if (held_valid !== expd.held_valid) begin
                    $display("FAIL %0t: held_valid %0b, expected %0b",
                             $time, held_valid, expd.held_valid);
                    value_errors++;
                end
                if (held_code !== expd.held_code) begin
                    $display("FAIL %0t: held_code %0d, expected %0d",
                             $time, held_code, expd.held_code);
                    value_errors++;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rstn && frame_err) ferr_count++;
    end

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("Timeout: the run did not end within %0d clock cycles", WATCHDOG_CLKS);
        $display("*** FAILED ***");
        $finish;
    end

    // ##############################
    // Stimulus
    // ##############################

    initial begin
        int         idx;
        int         ferr_before;
        logic [7:0] rb;
        rstn     = 1'b0;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        wait_clks(20);

        // Every table key pressed once
        foreach (table_bytes[k]) send_byte(table_bytes[k]);

        // Release of another key, then of the held one
        send_byte(8'h45);
        send_byte(SC_BREAK);
        send_byte(8'h16);
        send_byte(SC_BREAK);
        send_byte(8'h45);
        repeat (RAND_PRESSES) begin
            idx = {$random(seed)} % 19;
            send_byte(table_bytes[idx]);
            send_byte(SC_BREAK);
            send_byte(table_bytes[idx]);
        end

        // Extended Enter press and release
        send_byte(SC_EXTEND);
        send_byte(8'h5A);
        send_byte(SC_EXTEND);
        send_byte(SC_BREAK);
        send_byte(8'h5A);

        repeat (RAND_UNMAPPED) begin
            rb = 8'($random(seed));
            while (table_code(rb) != KEY_NONE || rb == SC_EXTEND || rb == SC_BREAK) begin
                rb = 8'($random(seed));
            end
            send_byte(rb);
        end

        // Bad parity, then a clean frame
        ferr_before = ferr_count;
        send_frame(8'h1C, 1'b1, 1'b0, 11);
        if (ferr_count != ferr_before + 1) begin
            $display("Bad parity frame gave %0d frame_err pulses instead of one",
                     ferr_count - ferr_before);
            other_errors++;
        end
        send_byte(8'h1C);

        // Glitched clock, then an abandoned frame
        exp_q.push_back(ref_event(8'h66, 1'b0, 1'b0, model_held_valid, model_held_code));
        model_held_valid = 1'b1;
        model_held_code  = table_code(8'h66);
        send_frame(8'h66, 1'b0, 1'b1, 11);
        send_frame(8'h2B, 1'b0, 1'b0, 5);
        wait_clks(FRAME_TIMEOUT + 500);
        send_byte(8'h0D);

        wait_clks(200);
        if (exp_q.size() != 0) begin
            $display("%0d expected key events never arrived", exp_q.size());
            other_errors += exp_q.size();
        end
        if (ferr_count != 1) begin
            $display("frame_err pulsed %0d times over the run, only one expected", ferr_count);
            other_errors++;
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* src/ps2_kbd_top.sv */
`timescale 1ns/1ps

module ps2_kbd_top
    import ps2_kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output key_event_t key,
    output logic       key_valid,
    output logic       frame_err,
    output logic       held_valid,
    output logic [4:0] held_code
);

    logic       ps2_clk_fall;
    logic       ps2_data_f;
    logic [7:0] byte_data;
    logic       byte_valid;
    key_mod_t   mod;
    logic [4:0] code;
    logic       map_valid;

    ps2_line_filter u_filter (
        .clk          (clk),
        .rstn         (rstn),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .ps2_clk_fall (ps2_clk_fall),
        .ps2_data_f   (ps2_data_f)
    );

    ps2_frame_rx u_frame_rx (
        .clk          (clk),
        .rstn         (rstn),
        .ps2_clk_fall (ps2_clk_fall),
        .ps2_data_f   (ps2_data_f),
        .byte_data    (byte_data),
        .byte_valid   (byte_valid),
        .frame_err    (frame_err)
    );

    // Tracker and map see the same byte in parallel
    ps2_prefix_tracker u_tracker (
        .clk        (clk),
        .rstn       (rstn),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .mod        (mod)
    );

    scan_code_map u_map (
        .clk        (clk),
        .rstn       (rstn),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .code       (code),
        .map_valid  (map_valid)
    );

    key_event_merge u_merge (
        .clk        (clk),
        .rstn       (rstn),
        .code       (code),
        .map_valid  (map_valid),
        .mod        (mod),
        .key        (key),
        .key_valid  (key_valid),
        .held_valid (held_valid),
        .held_code  (held_code)
    );

endmodule

/* src/key_event_merge.sv */
`timescale 1ns/1ps

module key_event_merge
    import ps2_kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic [4:0] code,
    input  logic       map_valid,
    input  key_mod_t   mod,
    output key_event_t key,
    output logic       key_valid,
    output logic       held_valid,
    output logic [4:0] held_code
);

    logic is_key;

    // Prefix bytes only update the tracker
    assign is_key = map_valid && !mod.is_prefix;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            key_valid  <= 1'b0;
            held_valid <= 1'b0;
            held_code  <= KEY_NONE;
        end else begin
            key_valid <= is_key;
            if (is_key) begin
                if (!mod.released) begin
                    held_code  <= code;
                    held_valid <= 1'b1;
                end else if (code == held_code) begin
                    held_valid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_key) begin
            key.code     <= code;
            key.released <= mod.released;
            key.extended <= mod.extended;
        end
    end

endmodule

/* src/scan_code_map.sv */
`timescale 1ns/1ps

module scan_code_map
    import ps2_kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic [7:0] byte_data,
    input  logic       byte_valid,
    output logic [4:0] code,
    output logic       map_valid
);

    logic [4:0] lookup;

    // ##############################
    // Scan code set 2 table
    // ##############################

    always_comb begin
        case (byte_data)
            // Digits 0 to 9
            8'h45: lookup = 5'd0;
            8'h16: lookup = 5'd1;
            8'h1E: lookup = 5'd2;
            8'h26: lookup = 5'd3;
            8'h25: lookup = 5'd4;
            8'h2E: lookup = 5'd5;
            8'h36: lookup = 5'd6;
            8'h3D: lookup = 5'd7;
            8'h3E: lookup = 5'd8;
            8'h46: lookup = 5'd9;
            // Letters A to F
            8'h1C: lookup = 5'd10;
            8'h32: lookup = 5'd11;
            8'h21: lookup = 5'd12;
            8'h23: lookup = 5'd13;
            8'h24: lookup = 5'd14;
            8'h2B: lookup = 5'd15;
            8'h5A: lookup = KEY_ENTER;
            8'h66: lookup = KEY_BKSP;
            8'h0D: lookup = KEY_TAB;
            default: lookup = KEY_NONE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            map_valid <= 1'b0;
        end else begin
            map_valid <= byte_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            code <= lookup;
        end
    end

endmodule

/* src/ps2_prefix_tracker.sv */
`timescale 1ns/1ps

module ps2_prefix_tracker
    import ps2_kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic [7:0] byte_data,
    input  logic       byte_valid,
    output key_mod_t   mod
);

    logic pending_break;
    logic pending_ext;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pending_break <= 1'b0;
            pending_ext   <= 1'b0;
            mod           <= '0;
        end else if (byte_valid) begin
            if (byte_data == SC_EXTEND) begin
                pending_ext   <= 1'b1;
                mod.is_prefix <= 1'b1;
                mod.released  <= pending_break;
                mod.extended  <= 1'b1;
            end else if (byte_data == SC_BREAK) begin
                pending_break <= 1'b1;
                mod.is_prefix <= 1'b1;
                mod.released  <= 1'b1;
                mod.extended  <= pending_ext;
            end else begin
                // Key byte closes the sequence
                mod.is_prefix <= 1'b0;
                mod.released  <= pending_break;
                mod.extended  <= pending_ext;
                pending_break <= 1'b0;
                pending_ext   <= 1'b0;
            end
        end
    end

endmodule

/* src/ps2_frame_rx.sv */
`timescale 1ns/1ps

module ps2_frame_rx
    import ps2_kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       ps2_clk_fall,
    input  logic       ps2_data_f,
    output logic [7:0] byte_data,
    output logic       byte_valid,
    output logic       frame_err
);

    ps2_frame_u            frame;
    ps2_frame_u            frame_next;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [TIMEOUT_W-1:0]  idle_cnt;
    logic                  last_bit;
    logic                  frame_ok;
    logic                  timed_out;

    // New bit enters at the top, LSB first on the wire
    always_comb begin
        frame_next.raw = {ps2_data_f, frame.raw[FRAME_BITS-1:1]};
    end

    assign last_bit = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

    // Odd parity over data and parity bit
    assign frame_ok = (frame_next.fields.start == 1'b0)
                   && (frame_next.fields.stop == 1'b1)
                   && (^{frame_next.fields.parity, frame_next.fields.data});

    assign timed_out = (bit_cnt != '0)
                    && (idle_cnt == TIMEOUT_W'(FRAME_TIMEOUT - 1));

    // ##############################
    // Bit counter and result pulses
    // ##############################

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
            if (ps2_clk_fall) begin
                if (last_bit) begin
                    bit_cnt    <= '0;
                    byte_valid <= frame_ok;
                    frame_err  <= !frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (timed_out) begin
                bit_cnt <= '0;
            end
        end
    end

    // Idle time inside a frame
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            idle_cnt <= '0;
        end else if (ps2_clk_fall || bit_cnt == '0) begin
            idle_cnt <= '0;
        end else if (!timed_out) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ps2_clk_fall) begin
            frame <= frame_next;
        end
        if (ps2_clk_fall && last_bit) begin
            byte_data <= frame_next.fields.data;
        end
    end

endmodule

/* src/ps2_line_filter.sv */
`timescale 1ns/1ps

module ps2_line_filter
    import ps2_kbd_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    input  logic ps2_clk,
    input  logic ps2_data,
    output logic ps2_clk_fall,
    output logic ps2_data_f
);

    logic [SAMPLE_CNT_W-1:0]      div_cnt;
    logic                         sample_tick;
    logic [1:0]                   line_meta;
    logic [1:0]                   line_sync;
    logic [1:0][FILTER_TAPS-1:0]  hist;
    logic [1:0][FILTER_TAPS-1:0]  hist_next;
    logic [1:0]                   level;

    // Sample tick divider
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            div_cnt <= '0;
        end else if (sample_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign sample_tick = (div_cnt == SAMPLE_CNT_W'(SAMPLE_DIV - 1));

    // Pins are asynchronous to clk; index 0 is clock, 1 is data
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            line_meta <= 2'b11;
            line_sync <= 2'b11;
        end else begin
            line_meta <= {ps2_data, ps2_clk};
            line_sync <= line_meta;
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            hist_next[i] = {hist[i][FILTER_TAPS-2:0], line_sync[i]};
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hist         <= '1;
            level        <= 2'b11;
            ps2_clk_fall <= 1'b0;
        end else begin
            ps2_clk_fall <= 1'b0;
            if (sample_tick) begin
                hist <= hist_next;
                for (int i = 0; i < 2; i++) begin
                    if (hist_next[i] == '1) begin
                        level[i] <= 1'b1;
                    end else if (hist_next[i] == '0) begin
                        level[i] <= 1'b0;
                    end
                end
                // Falls together with the filtered clock level
                ps2_clk_fall <= level[0] && (hist_next[0] == '0);
            end
        end
    end

    assign ps2_data_f = level[1];

endmodule

/* src/ps2_kbd_pkg.sv */
package ps2_kbd_pkg;

    // ##############################
    // Line sampling and framing
    // ##############################

    // clk cycles per line sample tick
    localparam int SAMPLE_DIV   = 4;
    localparam int SAMPLE_CNT_W = $clog2(SAMPLE_DIV);

    // Equal samples needed before a filtered level moves
    localparam int FILTER_TAPS = 8;

    // Start, 8 data, parity, stop
    localparam int FRAME_BITS = 11;
    localparam int BIT_CNT_W  = $clog2(FRAME_BITS);

    // Partial frame dropped after this many clk cycles without an edge
    localparam int FRAME_TIMEOUT = 1000;
    localparam int TIMEOUT_W     = $clog2(FRAME_TIMEOUT + 1);

    // ##############################
    // Scan codes and key codes
    // ##############################

    localparam logic [7:0] SC_EXTEND = 8'hE0;
    localparam logic [7:0] SC_BREAK  = 8'hF0;

    localparam logic [4:0] KEY_ENTER = 5'd16;
    localparam logic [4:0] KEY_BKSP  = 5'd17;
    localparam logic [4:0] KEY_TAB   = 5'd18;
    localparam logic [4:0] KEY_NONE  = 5'd31;

    // ##############################
    // Types
    // ##############################

    // Bit order on the wire is start first, so after shifting right
    // the start bit sits at the bottom
    typedef struct packed {
        logic       stop;
        logic       parity;
        logic [7:0] data;
        logic       start;
    } ps2_frame_t;

    typedef union packed {
        logic [FRAME_BITS-1:0] raw;
        ps2_frame_t            fields;
    } ps2_frame_u;

    // Prefix context for one received byte
    typedef struct packed {
        logic is_prefix;
        logic released;
        logic extended;
    } key_mod_t;

    typedef struct packed {
        logic [4:0] code;
        logic       released;
        logic       extended;
    } key_event_t;

endpackage
